// ==== Makefile ====
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f compile.f --top-module tbControl -o VtbControl
	./obj_dir/VtbControl +verilator+error+limit+1000 | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module tbControl

clean:
	rm -rf obj_dir $(LOG)

// ==== compile.f ====
src/controlPkg.sv
src/ctrlIf.sv
src/opcodeDecoder.sv
src/functDecoder.sv
src/ctrlMerge.sv
src/mipsControl.sv
tests/tbClock.sv
tests/tbScoreboard.sv
tests/mipsControl_checker.sv
tests/tbControl.sv

// ==== src/controlPkg.sv ====
package controlPkg;

    // ==============================
    // instruction field widths
    localparam int OP_W    = 6;                 // primary opcode
    localparam int FUNCT_W = 6;                 // r-type function field
    localparam int RT_W    = 5;                 // rt, also the regimm selector
    localparam int ALU_W   = 6;                 // alu operation code
    localparam int DM_W    = 2;                 // data memory mode
    localparam int WD_W    = 2;                 // write data source select

    localparam logic [RT_W-1:0] RT_BGEZ = 5'd1; // regimm rt for bgez

    // ==============================
    // instruction encodings
    typedef enum logic [OP_W-1:0] {
        OP_RTYPE  = 6'b000000,
        OP_REGIMM = 6'b000001,                  // bltz / bgez, split on rt
        OP_J      = 6'b000010,
        OP_JAL    = 6'b000011,
        OP_BEQ    = 6'b000100,
        OP_BNE    = 6'b000101,
        OP_BLEZ   = 6'b000110,
        OP_BGTZ   = 6'b000111,
        OP_ADDI   = 6'b001000,
        OP_LUI    = 6'b001111,
        OP_LB     = 6'b100000,
        OP_LH     = 6'b100001,
        OP_LW     = 6'b100011,
        OP_SB     = 6'b101000,
        OP_SH     = 6'b101001,
        OP_SW     = 6'b101011
    } opcode_t;

    typedef enum logic [FUNCT_W-1:0] {
        FN_JR   = 6'b001000,
        FN_MFHI = 6'b010000,
        FN_MTHI = 6'b010001,
        FN_MFLO = 6'b010010,
        FN_MTLO = 6'b010011
    } funct_t;

    // alu codes as the datapath alu expects them
    typedef enum logic [ALU_W-1:0] {
        ALU_AND   = 6'b000000,
        ALU_ADD   = 6'b000010,
        ALU_MOVTH = 6'b001010,
        ALU_MOVTL = 6'b001011,
        ALU_MFHI  = 6'b001100,
        ALU_MFLO  = 6'b001101,
        ALU_BEQ   = 6'b010000,
        ALU_BGTZ  = 6'b010001,
        ALU_BGEZ  = 6'b010010,
        ALU_BLEZ  = 6'b010011,
        ALU_BLTZ  = 6'b010100,
        ALU_BNE   = 6'b010101,
        ALU_LUI   = 6'b100000              // imm << 16
    } aluCode_t;

    typedef enum logic [DM_W-1:0] {
        DM_WORD = 2'b00,
        DM_HALF = 2'b01,
        DM_BYTE = 2'b10
    } dmMode_t;

    typedef enum logic [WD_W-1:0] {
        WD_MEMALU = 2'b00,                      // memtoReg mux output
        WD_REG31  = 2'b01,                      // jal target register
        WD_LINKPC = 2'b11                       // pc + 4
    } writeDst_t;

    // ==============================
    // datapath control flags, regDst is the msb
    typedef struct packed {
        logic regDst;                           // rd instead of rt
        logic branch;
        logic memRead;
        logic memtoReg;                         // alu result instead of memory data
        logic memWrite;
        logic aluSrc2;                          // immExt on alu input b
        logic aluSrc1;                          // shift amount on alu input a
        logic regWrite;
        logic signExt;                          // sign extend the immediate
        logic jump;
        logic condMov;                          // gated by alu zero flag
    } ctrlFlags_t;

    // rows shared by both decoders
    localparam ctrlFlags_t RTYPE_FLAGS = '{regDst: 1'b1, memtoReg: 1'b1, regWrite: 1'b1,
                                           default: 1'b0};
    localparam ctrlFlags_t JUMP_FLAGS  = '{jump: 1'b1, signExt: 1'b1, default: 1'b0};

endpackage

// ==== src/ctrlIf.sv ====
`timescale 1ns/1ps

// one decoded control word, decoder to merge stage
interface ctrlIf;
    import controlPkg::*;

    ctrlFlags_t flags;                          // datapath flags
    aluCode_t   aluCode;                        // alu operation
    dmMode_t    dmMode;                         // word / half / byte
    writeDst_t  writeDst;                       // write data source

    // decoder side
    modport src (
        output flags,
        output aluCode,
        output dmMode,
        output writeDst
    );

    // merge side
    modport dst (
        input flags,
        input aluCode,
        input dmMode,
        input writeDst
    );

endinterface

// ==== src/ctrlMerge.sv ====
`timescale 1ns/1ps

module ctrlMerge (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  instrValid,   // new instruction this edge
    input  logic                  isRType,      // take the function word
    ctrlIf.dst                    opWord,
    ctrlIf.dst                    fnWord,
    output controlPkg::ctrlFlags_t ctrlFlags,
    output controlPkg::aluCode_t   aluControl,
    output controlPkg::dmMode_t    dmControl,
    output controlPkg::writeDst_t  writeDst,
    output logic                  ctrlValid
);
    import controlPkg::*;

    ctrlFlags_t selFlags;
    aluCode_t   selAlu;
    dmMode_t    selDm;
    writeDst_t  selWd;

    // ==============================
    // word select
    always_comb begin
        if (isRType) begin
            selFlags = fnWord.flags;
            selAlu   = fnWord.aluCode;
            selDm    = fnWord.dmMode;
            selWd    = fnWord.writeDst;
        end else begin
            selFlags = opWord.flags;
            selAlu   = opWord.aluCode;
            selDm    = opWord.dmMode;
            selWd    = opWord.writeDst;
        end
    end

    // ==============================
    // output register, one cycle latency
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ctrlValid  <= 1'b0;
            ctrlFlags  <= '0;
            aluControl <= ALU_AND;              // all zero codes
            dmControl  <= DM_WORD;
            writeDst   <= WD_MEMALU;
        end else begin
            ctrlValid <= instrValid;            // valid follows input by one edge
            if (instrValid) begin
                ctrlFlags  <= selFlags;
                aluControl <= selAlu;
                dmControl  <= selDm;
                writeDst   <= selWd;
            end                                 // otherwise hold last word
        end
    end

endmodule

// ==== src/functDecoder.sv ====
`timescale 1ns/1ps

module functDecoder (
    input  controlPkg::funct_t funct,           // r-type function field
    ctrlIf.src                 fnWord           // decoded word
);
    import controlPkg::*;

    ctrlFlags_t flags;
    aluCode_t   aluCode;

    // ==============================
    // function table, runs beside the opcode decoder
    always_comb begin
        flags   = RTYPE_FLAGS;                  // most rows write rd
        aluCode = ALU_AND;
        case (funct)
            FN_MTHI: begin
                aluCode = ALU_MOVTH;
            end
            FN_MTLO: begin
                aluCode = ALU_MOVTL;
            end
            FN_MFHI: begin
                aluCode = ALU_MFHI;
            end
            FN_MFLO: begin
                aluCode = ALU_MFLO;
            end
            FN_JR: begin
                flags = JUMP_FLAGS;             // R[rs] to pc, no write back
            end
            default: begin
                aluCode = ALU_AND;              // unlisted codes act as and
            end
        endcase
    end

    assign fnWord.flags    = flags;
    assign fnWord.aluCode  = aluCode;
    assign fnWord.dmMode   = DM_WORD;           // no memory access on r-type
    assign fnWord.writeDst = WD_MEMALU;         // jr included

endmodule

// ==== src/mipsControl.sv ====
`timescale 1ns/1ps

module mipsControl (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic                           instrValid,
    input  logic [controlPkg::OP_W-1:0]    op,
    input  logic [controlPkg::FUNCT_W-1:0] funct,
    input  logic [controlPkg::RT_W-1:0]    rt,
    output logic                           ctrlValid,
    output logic                           regDst,
    output logic                           branch,
    output logic                           memRead,
    output logic                           memtoReg,
    output logic                           memWrite,
    output logic                           aluSrc2,
    output logic                           aluSrc1,
    output logic                           regWrite,
    output logic                           signExt,
    output logic                           jump,
    output logic                           condMov,
    output logic [controlPkg::ALU_W-1:0]   aluControl,
    output logic [controlPkg::DM_W-1:0]    dmControl,
    output logic [controlPkg::WD_W-1:0]    writeDst
);
    import controlPkg::*;

    opcode_t    opCode;
    funct_t     fnCode;
    logic       isRType;
    ctrlFlags_t flagsQ;                         // registered flags
    aluCode_t   aluQ;
    dmMode_t    dmQ;
    writeDst_t  wdQ;

    assign opCode = opcode_t'(op);              // raw field onto the enum
    assign fnCode = funct_t'(funct);

    ctrlIf opWord ();
    ctrlIf fnWord ();

    // ==============================
    // decode and register
    opcodeDecoder i_opDec (.op(opCode), .rt(rt), .opWord(opWord), .isRType(isRType));

    functDecoder i_fnDec (.funct(fnCode), .fnWord(fnWord));

    ctrlMerge i_merge (
        .clk(clk), .arstN(arstN), .instrValid(instrValid), .isRType(isRType),
        .opWord(opWord), .fnWord(fnWord),
        .ctrlFlags(flagsQ), .aluControl(aluQ), .dmControl(dmQ), .writeDst(wdQ),
        .ctrlValid(ctrlValid)
    );

    // flag struct out onto single bit ports
    assign regDst   = flagsQ.regDst;
    assign branch   = flagsQ.branch;
    assign memRead  = flagsQ.memRead;
    assign memtoReg = flagsQ.memtoReg;
    assign memWrite = flagsQ.memWrite;
    assign aluSrc2  = flagsQ.aluSrc2;
    assign aluSrc1  = flagsQ.aluSrc1;           // always zero for now
    assign regWrite = flagsQ.regWrite;
    assign signExt  = flagsQ.signExt;
    assign jump     = flagsQ.jump;
    assign condMov  = flagsQ.condMov;           // always zero for now

    assign aluControl = aluQ;
    assign dmControl  = dmQ;
    assign writeDst   = wdQ;

endmodule

// ==== src/opcodeDecoder.sv ====
`timescale 1ns/1ps

module opcodeDecoder (
    input  controlPkg::opcode_t     op,         // primary opcode
    input  logic [controlPkg::RT_W-1:0] rt,     // regimm branch selector
    ctrlIf.src                      opWord,     // decoded word
    output logic                    isRType     // function field decides
);
    import controlPkg::*;

    ctrlFlags_t flags;
    aluCode_t   aluCode;
    dmMode_t    dmMode;
    writeDst_t  writeDst;

    // ==============================
    // opcode table
    always_comb begin
        flags    = '0;                          // start from an empty row
        aluCode  = ALU_AND;
        dmMode   = DM_WORD;
        writeDst = WD_MEMALU;
        case (op)
            OP_LW, OP_LH, OP_LB: begin
                flags.memRead  = 1'b1;
                flags.aluSrc2  = 1'b1;          // base + offset
                flags.regWrite = 1'b1;
                flags.signExt  = 1'b1;
                aluCode        = ALU_ADD;
                if (op == OP_LH) begin
                    dmMode = DM_HALF;
                end else if (op == OP_LB) begin
                    dmMode = DM_BYTE;
                end
            end
            OP_LUI: begin
                flags.memRead  = 1'b1;          // kept high as in the datapath
                flags.aluSrc2  = 1'b1;
                flags.regWrite = 1'b1;
                flags.signExt  = 1'b1;          // don't care
                aluCode        = ALU_LUI;
            end
            OP_SW, OP_SH, OP_SB: begin
                flags.memWrite = 1'b1;
                flags.aluSrc2  = 1'b1;          // base + offset
                flags.signExt  = 1'b1;
                aluCode        = ALU_ADD;
                if (op == OP_SH) begin
                    dmMode = DM_HALF;
                end else if (op == OP_SB) begin
                    dmMode = DM_BYTE;
                end
            end
            OP_BEQ: begin
                flags.branch  = 1'b1;
                flags.signExt = 1'b1;           // signed word offset
                aluCode       = ALU_BEQ;
            end
            OP_BNE: begin
                flags.branch  = 1'b1;
                flags.signExt = 1'b1;
                aluCode       = ALU_BNE;
            end
            OP_BGTZ: begin
                flags.branch  = 1'b1;
                flags.signExt = 1'b1;
                aluCode       = ALU_BGTZ;
            end
            OP_BLEZ: begin
                flags.branch  = 1'b1;
                flags.signExt = 1'b1;
                aluCode       = ALU_BLEZ;
            end
            OP_REGIMM: begin
                flags.branch  = 1'b1;
                flags.signExt = 1'b1;
                // rt 1 is bgez, everything else falls to bltz
                aluCode       = (rt == RT_BGEZ) ? ALU_BGEZ : ALU_BLTZ;
            end
            OP_J: begin
                flags = JUMP_FLAGS;
            end
            OP_JAL: begin
                flags    = JUMP_FLAGS;
                writeDst = WD_REG31;            // return address to $31
            end
            OP_ADDI: begin
                flags.memtoReg = 1'b1;          // alu result back
                flags.aluSrc2  = 1'b1;
                flags.regWrite = 1'b1;
                flags.signExt  = 1'b1;
                aluCode        = ALU_ADD;
            end
            default: begin
                flags = RTYPE_FLAGS;            // and row, also rtype
            end
        endcase
    end

    assign opWord.flags    = flags;
    assign opWord.aluCode  = aluCode;
    assign opWord.dmMode   = dmMode;
    assign opWord.writeDst = writeDst;

    assign isRType = (op == OP_RTYPE);          // hand over to functDecoder

endmodule

// ==== tests/control_tests.txt ====
# columns in hex: op funct rt aluControl dmControl writeDst flags
# flags msb first: regDst branch memRead memtoReg memWrite aluSrc2 aluSrc1 regWrite signExt jump condMov
00 11 00 0a 0 0 488
00 13 00 0b 0 0 488
00 10 00 0c 0 0 488
00 12 00 0d 0 0 488
00 21 07 00 0 0 488
00 08 00 00 0 0 006
23 00 00 02 0 0 12c
21 00 00 02 1 0 12c
20 00 00 02 2 0 12c
23 08 03 02 0 0 12c
0f 00 00 20 0 0 12c
2b 00 00 02 0 0 064
29 00 00 02 1 0 064
28 00 00 02 2 0 064
04 00 00 10 0 0 204
05 00 00 15 0 0 204
07 00 00 11 0 0 204
06 00 00 13 0 0 204
01 00 01 12 0 0 204
01 00 00 14 0 0 204
01 00 05 14 0 0 204
02 00 00 00 0 0 006
03 00 00 00 0 1 006
08 00 00 02 0 0 0ac
0d 00 00 00 0 0 488

// ==== tests/mipsControl_checker.sv ====
`timescale 1ns/1ps

module mipsControl_checker (
    input logic clk,
    input logic arstN,
    input logic instrValid,
    input logic ctrlValid,
    input logic memRead,
    input logic memWrite,
    input logic branch,
    input logic jump
);

    int assertFails = 0;                        // read by the testbench top

    // ==============================
    // reset and valid timing
    resetLow: assert property (@(posedge clk) !arstN |-> !ctrlValid)
        else begin
            $error("ctrlValid high while in reset");
            assertFails++;
        end

    validFollows: assert property (@(posedge clk) disable iff (!arstN)
                                   ctrlValid == $past(instrValid))
        else begin
            $error("ctrlValid does not follow instrValid by one cycle");
            assertFails++;
        end

    // ==============================
    // flags that exclude each other
    memExclusive: assert property (@(posedge clk) !(memRead && memWrite))
        else begin
            $error("memRead and memWrite high together");
            assertFails++;
        end

    branchOrJump: assert property (@(posedge clk) !(branch && jump))
        else begin
            $error("branch and jump high together");
            assertFails++;
        end

endmodule

bind mipsControl mipsControl_checker i_chk (
    .clk(clk), .arstN(arstN), .instrValid(instrValid), .ctrlValid(ctrlValid),
    .memRead(memRead), .memWrite(memWrite), .branch(branch), .jump(jump)
);

// ==== tests/tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                  // 4 ns period
    end

    initial begin
        arstN = 1'b0;
        repeat (4) @(posedge clk);              // held for 4 cycles
        #1 arstN = 1'b1;                        // release off the edge
    end

endmodule

// ==== tests/tbControl.sv ====
`timescale 1ns/1ps

module tbControl;
    import controlPkg::*;

    logic               clk;
    logic               arstN;
    logic               instrValid;
    logic [OP_W-1:0]    op;
    logic [FUNCT_W-1:0] funct;
    logic [RT_W-1:0]    rt;
    logic               ctrlValid;
    logic regDst, branch, memRead, memtoReg, memWrite, aluSrc2,
          aluSrc1, regWrite, signExt, jump, condMov;
    logic [ALU_W-1:0]   aluControl;
    logic [DM_W-1:0]    dmControl;
    logic [WD_W-1:0]    writeDst;
    ctrlFlags_t         dutFlags;               // single bits packed back up
    logic [ALU_W-1:0]   expAlu;
    logic [DM_W-1:0]    expDm;
    logic [WD_W-1:0]    expWd;
    ctrlFlags_t         expFlags;
    logic [6:0][15:0]   entries [$];            // op funct rt alu dm wd flags
    int checks;
    int valueErrs;
    int protoErrs;
    int setupErrs  = 0;
    int cycles     = 0;
    int cycleLimit = 20;

    tbClock i_clk (.clk(clk), .arstN(arstN));

    mipsControl i_dut (
        .clk(clk), .arstN(arstN), .instrValid(instrValid), .op(op), .funct(funct), .rt(rt),
        .ctrlValid(ctrlValid), .regDst(regDst), .branch(branch), .memRead(memRead),
        .memtoReg(memtoReg), .memWrite(memWrite), .aluSrc2(aluSrc2), .aluSrc1(aluSrc1),
        .regWrite(regWrite), .signExt(signExt), .jump(jump), .condMov(condMov),
        .aluControl(aluControl), .dmControl(dmControl), .writeDst(writeDst)
    );

    assign dutFlags = {regDst, branch, memRead, memtoReg, memWrite, aluSrc2,
                       aluSrc1, regWrite, signExt, jump, condMov};

    tbScoreboard i_sb (
        .clk(clk), .arstN(arstN), .instrValid(instrValid),
        .expAlu(expAlu), .expDm(expDm), .expWd(expWd), .expFlags(expFlags),
        .ctrlValid(ctrlValid), .aluControl(aluControl), .dmControl(dmControl),
        .writeDst(writeDst), .flags(dutFlags),
        .checks(checks), .valueErrs(valueErrs), .protoErrs(protoErrs)
    );

    task automatic loadTests();
        int          fd;
        string       line;
        logic [15:0] fOp, fFn, fRt, fAlu, fDm, fWd, fFl;
        fd = $fopen("tests/control_tests.txt", "r");
        if (fd == 0) begin
            setupErrs++;
            $display("cannot open tests/control_tests.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            // comment and blank lines do not scan
            if ($sscanf(line, "%h %h %h %h %h %h %h",
                        fOp, fFn, fRt, fAlu, fDm, fWd, fFl) == 7) begin
                entries.push_back({fOp, fFn, fRt, fAlu, fDm, fWd, fFl});
            end
        end
        $fclose(fd);
        if (entries.size() == 0) begin
            setupErrs++;
            $display("no test entries found in tests/control_tests.txt");
        end
    endtask

    // ==============================
    // stimulus and final report
    initial begin
        int gap;
        int fails;
        void'($urandom(32'ha37b_3c18));
        instrValid = 1'b0;
        op         = '0;
        funct      = '0;
        rt         = '0;
        expAlu     = '0;
        expDm      = '0;
        expWd      = '0;
        expFlags   = '0;
        loadTests();
        cycleLimit = 4 * entries.size() + 20;
        wait (arstN === 1'b1);
        foreach (entries[i]) begin
            gap = $urandom_range(2, 0);         // idle cycles before this one
            repeat (gap) begin
                @(posedge clk);
                #1 instrValid = 1'b0;
            end
            @(posedge clk);
            #1;
            op         = entries[i][6][OP_W-1:0];
            funct      = entries[i][5][FUNCT_W-1:0];
            rt         = entries[i][4][RT_W-1:0];
            expAlu     = entries[i][3][ALU_W-1:0];
            expDm      = entries[i][2][DM_W-1:0];
            expWd      = entries[i][1][WD_W-1:0];
            expFlags   = entries[i][0][10:0];
            instrValid = 1'b1;
        end
        @(posedge clk);
        #1 instrValid = 1'b0;
        repeat (3) @(posedge clk);              // drain the last word
        if (checks != entries.size()) begin
            setupErrs++;
            $display("only %0d of %0d instructions came out", checks, entries.size());
        end
        fails = valueErrs + protoErrs + setupErrs + i_dut.i_chk.assertFails;
        $display("checked %0d, mismatches %0d, protocol %0d, assertions %0d, other %0d",
                 checks, valueErrs, protoErrs, i_dut.i_chk.assertFails, setupErrs);
        if (fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // run limit scales with the entry count
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("timeout: run went past %0d cycles", cycleLimit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

endmodule

// ==== tests/tbScoreboard.sv ====
`timescale 1ns/1ps

module tbScoreboard (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic                         instrValid,   // taken at the next edge
    input  logic [controlPkg::ALU_W-1:0] expAlu,
    input  logic [controlPkg::DM_W-1:0]  expDm,
    input  logic [controlPkg::WD_W-1:0]  expWd,
    input  controlPkg::ctrlFlags_t       expFlags,
    input  logic                         ctrlValid,
    input  logic [controlPkg::ALU_W-1:0] aluControl,
    input  logic [controlPkg::DM_W-1:0]  dmControl,
    input  logic [controlPkg::WD_W-1:0]  writeDst,
    input  controlPkg::ctrlFlags_t       flags,
    output int                           checks,
    output int                           valueErrs,
    output int                           protoErrs
);
    import controlPkg::*;

    typedef struct packed {
        logic [ALU_W-1:0] alu;
        logic [DM_W-1:0]  dm;
        logic [WD_W-1:0]  wd;
        ctrlFlags_t       flags;
    } word_t;

    string flagNames [11] = '{"regDst", "branch", "memRead", "memtoReg", "memWrite",
                              "aluSrc2", "aluSrc1", "regWrite", "signExt", "jump", "condMov"};
    word_t expQ [$];                            // accepted and not yet seen
    word_t want;
    logic  sawWord = 1'b0;                      // zero outputs until the first word

    initial begin
        checks    = 0;
        valueErrs = 0;
        protoErrs = 0;
    end

    task automatic compareField(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            valueErrs++;
            $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // ==============================
    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (ctrlValid) begin
            sawWord = 1'b1;
            if (expQ.size() == 0) begin
                protoErrs++;
                $display("ctrlValid high at %0t with no instruction accepted", $time);
            end else begin
                want = expQ.pop_front();
                checks++;
                compareField("aluControl", 32'(aluControl), 32'(want.alu));
                compareField("dmControl", 32'(dmControl), 32'(want.dm));
                compareField("writeDst", 32'(writeDst), 32'(want.wd));
                for (int i = 0; i < $bits(ctrlFlags_t); i++) begin
                    compareField(flagNames[i], 32'(flags[$bits(ctrlFlags_t) - 1 - i]),
                                 32'(want.flags[$bits(ctrlFlags_t) - 1 - i]));   // msb first
                end
            end
        end else if (expQ.size() != 0) begin
            protoErrs++;
            $display("no ctrlValid one cycle after an accepted instruction at %0t", $time);
            void'(expQ.pop_front());
        end else if (!sawWord && {aluControl, dmControl, writeDst, flags} !== '0) begin
            protoErrs++;
            $display("control outputs not zero during or after reset at %0t", $time);
        end
        if (arstN && instrValid) begin
            expQ.push_back({expAlu, expDm, expWd, expFlags});   // due one edge later
        end
    end

endmodule
